// File: vlog.f
source/wakeupPkg.sv
source/wakeupLane.sv
source/flushWindowTracker.sv
source/wakeupPipeTop.sv
verif/tbClockGen.sv
verif/wakeupChecker.sv
verif/wakeupTb.sv

// File: Bender.yml
package:
  name: wakeup_pipe

sources:
  - files:
      - source/wakeupPkg.sv
      - source/wakeupLane.sv
      - source/flushWindowTracker.sv
      - source/wakeupPipeTop.sv
  - target: test
    files:
      - verif/tbClockGen.sv
      - verif/wakeupChecker.sv
      - verif/wakeupTb.sv

// File: verif/wakeupTb.sv
// Testbench top with seeded random stimulus in one phase per behavior.
// Inputs change 1 ns after the rising edge; wakeupChecker does all comparing.

`timescale 1ns/1ps

module wakeupTb import wakeupPkg::*; ();

    localparam int TIMEOUT_CYCLES = 64;

    logic     clk;
    logic     arstN;
    logic     stall;
    logic     selected [ISSUE_WIDTH];
    iqIndexT  selectedPtr [ISSUE_WIDTH];
    iqOneHotT selectedVector [ISSUE_WIDTH];
    alIndexT  selectedActiveListPtr [ISSUE_WIDTH];
    logic     toRecoveryPhase;
    logic     recoveryFromRwStage;
    iqOneHotT flushIqEntry;
    alIndexT  flushRangeHeadPtr;
    alIndexT  flushRangeTailPtr;
    logic     flushAllInsns;
    logic     wakeup [ISSUE_WIDTH];
    iqIndexT  wakeupPtr [ISSUE_WIDTH];
    iqOneHotT wakeupVector [ISSUE_WIDTH];
    logic     releaseEntry [ISSUE_WIDTH];
    iqIndexT  releasePtr [ISSUE_WIDTH];
    logic     flushedOpExist;
    int       errorCount;
    int       checkCount;
    int       seed;
    int       phaseErrorBase;

    tbClockGen #(
        .periodNs   (10),
        .resetCycles(16)
    ) tbClockGen_inst (
        .clk  (clk),
        .arstN(arstN)
    );

    wakeupPipeTop wakeupPipeTop_inst (
        .clk(clk), .arstN(arstN), .stall(stall),
        .selected(selected), .selectedPtr(selectedPtr), .selectedVector(selectedVector),
        .selectedActiveListPtr(selectedActiveListPtr),
        .toRecoveryPhase(toRecoveryPhase), .recoveryFromRwStage(recoveryFromRwStage),
        .flushIqEntry(flushIqEntry), .flushRangeHeadPtr(flushRangeHeadPtr),
        .flushRangeTailPtr(flushRangeTailPtr), .flushAllInsns(flushAllInsns),
        .wakeup(wakeup), .wakeupPtr(wakeupPtr), .wakeupVector(wakeupVector),
        .releaseEntry(releaseEntry), .releasePtr(releasePtr), .flushedOpExist(flushedOpExist)
    );

    wakeupChecker wakeupChecker_inst (
        .clk(clk), .arstN(arstN), .stall(stall),
        .selected(selected), .selectedPtr(selectedPtr), .selectedVector(selectedVector),
        .selectedActiveListPtr(selectedActiveListPtr),
        .toRecoveryPhase(toRecoveryPhase), .recoveryFromRwStage(recoveryFromRwStage),
        .flushIqEntry(flushIqEntry), .flushRangeHeadPtr(flushRangeHeadPtr),
        .flushRangeTailPtr(flushRangeTailPtr), .flushAllInsns(flushAllInsns),
        .wakeup(wakeup), .wakeupPtr(wakeupPtr), .wakeupVector(wakeupVector),
        .releaseEntry(releaseEntry), .releasePtr(releasePtr), .flushedOpExist(flushedOpExist),
        .errorCount(errorCount), .checkCount(checkCount)
    );

    task automatic nextCycle();
        @(posedge clk);
        #1;
    endtask

    task automatic randomInputs(input int stallPct, input bit withIqFlush);
        int victim;
        stall = ($unsigned($random(seed)) % 100) < stallPct;
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            selected[s] = ($unsigned($random(seed)) % 4) != 0;
            selectedPtr[s] = iqIndexT'($random(seed));
            selectedVector[s] = iqOneHotT'($random(seed));
            selectedActiveListPtr[s] = alIndexT'($random(seed));
        end
        toRecoveryPhase = 1'b0;
        recoveryFromRwStage = 1'b0;
        flushIqEntry = '0;
        if (withIqFlush) begin
            flushIqEntry = iqOneHotT'($random(seed) & $random(seed));
            // Always hit one selected entry so the capture mask is exercised.
            victim = $unsigned($random(seed)) % ISSUE_WIDTH;
            selected[victim] = 1'b1;
            flushIqEntry[selectedPtr[victim]] = 1'b1;
        end
    endtask

    task automatic idleInputs();
        randomInputs(0, 1'b0);
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            selected[s] = 1'b0;
        end
        flushRangeHeadPtr = '0;
        flushRangeTailPtr = '0;
        flushAllInsns = 1'b0;
    endtask

    task automatic finishPhase(input string name);
        int phaseErrors;
        phaseErrors = errorCount - phaseErrorBase;
        if (phaseErrors == 0) begin
            $display("Phase %s: pass", name);
        end
        else begin
            $display("Phase %s: fail, %0d mismatches", name, phaseErrors);
        end
        phaseErrorBase = errorCount;
    endtask

    task automatic stopOnFailure(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $finish;
    endtask

    initial begin
        int waited;
        seed = 26814;
        phaseErrorBase = 0;
        idleInputs();

        waited = 0;
        while (!arstN && waited < TIMEOUT_CYCLES) begin
            @(posedge clk);
            waited++;
        end
        if (!arstN) begin
            stopOnFailure("Timeout: reset was never released.");
        end
        repeat (10) nextCycle();
        finishPhase("reset and idle");

        for (int c = 0; c < 200; c++) begin
            nextCycle();
            randomInputs(0, 1'b0);
        end
        finishPhase("latency without stall");

        for (int c = 0; c < 200; c++) begin
            nextCycle();
            randomInputs(30, 1'b0);
        end
        finishPhase("random stall");

        for (int c = 0; c < 200; c++) begin
            nextCycle();
            randomInputs(20, 1'b1);
        end
        finishPhase("issue-queue flush masking");

        for (int c = 0; c < 200; c++) begin
            nextCycle();
            randomInputs(20, 1'b1);
            if (c % 6 == 5) begin
                toRecoveryPhase = 1'b1;
            end
        end
        finishPhase("commit recovery");

        for (int r = 0; r < 16; r++) begin
            repeat (4) begin
                nextCycle();
                randomInputs(25, 1'b0);
            end
            nextCycle();
            randomInputs(25, 1'b0);
            toRecoveryPhase = 1'b1;
            recoveryFromRwStage = 1'b1;
            flushRangeHeadPtr = alIndexT'($random(seed));
            flushRangeTailPtr = alIndexT'($random(seed));
            flushAllInsns = ($unsigned($random(seed)) % 4) == 0;
            nextCycle();
            randomInputs(25, 1'b0);
            waited = 0;
            while (flushedOpExist && waited < TIMEOUT_CYCLES) begin
                nextCycle();
                randomInputs(25, 1'b0);
                waited++;
            end
            if (flushedOpExist) begin
                stopOnFailure("Timeout: flushedOpExist stayed high after a recovery.");
            end
        end
        finishPhase("register-write recovery");

        idleInputs();
        repeat (5) nextCycle();
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("Simulation PASSED");
            $finish;
        end
        else begin
            stopOnFailure("The DUT differed from the reference model.");
        end
    end

endmodule

// File: verif/wakeupChecker.sv
// Reference model of the wakeup lanes and the flush window counters.
// Samples inputs and outputs at each rising edge, before the DUT registers update.
// Pointers are compared only while the slot releases an entry.

`timescale 1ns/1ps

module wakeupChecker import wakeupPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  logic     stall,
    input  logic     selected [ISSUE_WIDTH],
    input  iqIndexT  selectedPtr [ISSUE_WIDTH],
    input  iqOneHotT selectedVector [ISSUE_WIDTH],
    input  alIndexT  selectedActiveListPtr [ISSUE_WIDTH],
    input  logic     toRecoveryPhase,
    input  logic     recoveryFromRwStage,
    input  iqOneHotT flushIqEntry,
    input  alIndexT  flushRangeHeadPtr,
    input  alIndexT  flushRangeTailPtr,
    input  logic     flushAllInsns,
    input  logic     wakeup [ISSUE_WIDTH],
    input  iqIndexT  wakeupPtr [ISSUE_WIDTH],
    input  iqOneHotT wakeupVector [ISSUE_WIDTH],
    input  logic     releaseEntry [ISSUE_WIDTH],
    input  iqIndexT  releasePtr [ISSUE_WIDTH],
    input  logic     flushedOpExist,
    output int       errorCount,
    output int       checkCount
);

    // Model stages sized for the deepest lane.
    logic     mValid [ISSUE_WIDTH][MEM_LATENCY];
    iqIndexT  mPtr [ISSUE_WIDTH][MEM_LATENCY];
    iqOneHotT mVec [ISSUE_WIDTH][MEM_LATENCY];
    alIndexT  mAl [ISSUE_WIDTH][MEM_LATENCY];
    int       intCnt;
    int       memCnt;
    alIndexT  mHead;
    alIndexT  mTail;
    logic     mFlushAll;

    initial begin
        errorCount = 0;
        checkCount = 0;
    end

    function automatic int laneDepth(input int slot);
        return (slot < INT_ISSUE_WIDTH) ? INT_LATENCY : MEM_LATENCY;
    endfunction

    // The distance from head modulo the active list size must be below the range length.
    function automatic logic covered(input alIndexT ptr);
        alIndexT offset;
        alIndexT span;
        offset = ptr - mHead;
        span = mTail - mHead;
        return mFlushAll || (offset < span);
    endfunction

    function automatic int countDown(input int cnt, input int full);
        if (cnt == full) begin
            return stall ? cnt : cnt - 1;
        end
        return (cnt > 0) ? cnt - 1 : 0;
    endfunction

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] got);
        checkCount++;
        if (exp !== got) begin
            errorCount++;
            $display("[ERROR] %0t ns: %s expected 0x%0h, got 0x%0h", $time, what, exp, got);
        end
    endtask

    task automatic resetModel();
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            for (int i = 0; i < MEM_LATENCY; i++) begin
                mValid[s][i] = 1'b0;
                mVec[s][i] = '0;
            end
        end
        intCnt = 0;
        memCnt = 0;
        mHead = '0;
        mTail = '0;
        mFlushAll = 1'b0;
    endtask

    task automatic checkOutputs();
        int last;
        logic gate;
        logic expRel;
        logic expWin;
        logic expWake;
        iqOneHotT expVec;
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            last = laneDepth(s) - 1;
            gate = (laneDepth(s) == 1) && stall;
            expRel = mValid[s][last] && !gate;
            expWin = (s < INT_ISSUE_WIDTH) ? (intCnt != 0) : (memCnt != 0);
            expWake = expRel && !(expWin && covered(mAl[s][last]));
            expVec = gate ? '0 : mVec[s][last];
            compare($sformatf("releaseEntry[%0d]", s), expRel, releaseEntry[s]);
            compare($sformatf("wakeup[%0d]", s), expWake, wakeup[s]);
            compare($sformatf("wakeupVector[%0d]", s), expVec, wakeupVector[s]);
            if (expRel) begin
                compare($sformatf("wakeupPtr[%0d]", s), mPtr[s][last], wakeupPtr[s]);
                compare($sformatf("releasePtr[%0d]", s), mPtr[s][last], releasePtr[s]);
            end
        end
        compare("flushedOpExist", (intCnt != 0) || (memCnt != 0), flushedOpExist);
    endtask

    task automatic stepModel();
        int depth;
        if (toRecoveryPhase && !recoveryFromRwStage) begin
            resetLanes();
        end
        else begin
            for (int s = 0; s < ISSUE_WIDTH; s++) begin
                depth = laneDepth(s);
                // Walk from the exit so each stage reads its predecessor's old value.
                for (int i = depth - 1; i >= 1; i--) begin
                    if (stall && i == 1) begin
                        mValid[s][1] = 1'b0;
                        mVec[s][1] = '0;
                    end
                    else begin
                        mValid[s][i] = mValid[s][i-1];
                        mPtr[s][i] = mPtr[s][i-1];
                        mVec[s][i] = mVec[s][i-1];
                        mAl[s][i] = mAl[s][i-1];
                    end
                end
                if (!stall) begin
                    mValid[s][0] = selected[s] && !flushIqEntry[selectedPtr[s]];
                    mPtr[s][0] = selectedPtr[s];
                    mVec[s][0] = selectedVector[s] & ~flushIqEntry;
                    mAl[s][0] = selectedActiveListPtr[s];
                end
            end
        end
        if (toRecoveryPhase && recoveryFromRwStage) begin
            intCnt = INT_LATENCY;
            memCnt = MEM_LATENCY;
            mHead = flushRangeHeadPtr;
            mTail = flushRangeTailPtr;
            mFlushAll = flushAllInsns;
        end
        else begin
            intCnt = countDown(intCnt, INT_LATENCY);
            memCnt = countDown(memCnt, MEM_LATENCY);
        end
    endtask

    task automatic resetLanes();
        for (int s = 0; s < ISSUE_WIDTH; s++) begin
            for (int i = 0; i < MEM_LATENCY; i++) begin
                mValid[s][i] = 1'b0;
                mVec[s][i] = '0;
            end
        end
    endtask

    always @(posedge clk) begin
        if (!arstN) begin
            resetModel();
        end
        checkOutputs();
        if (arstN) begin
            stepModel();
        end
    end

endmodule

// File: verif/tbClockGen.sv
// Free-running clock and power-on reset for the testbench.
// Reset falls 1 ns after time zero and rises 1 ns after the last reset edge.

`timescale 1ns/1ps

module tbClockGen #(
    parameter int periodNs = 10,
    parameter int resetCycles = 16
) (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    // Start high so that the asynchronous reset sees a real falling edge.
    initial begin
        arstN = 1'b1;
        #1 arstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        #1 arstN = 1'b1;
    end

endmodule

// File: source/wakeupPipeTop.sv
// Wakeup pipeline register of the issue scheduler.
// Slots 0-1 feed one-stage integer lanes, slots 2-3 feed three-stage memory lanes.
// Stall is the only back-pressure; selections made during stall are not recorded.

`timescale 1ns/1ps

module wakeupPipeTop import wakeupPkg::*; (
    input  logic     clk,
    input  logic     arstN,
    input  logic     stall,
    input  logic     selected [ISSUE_WIDTH],
    input  iqIndexT  selectedPtr [ISSUE_WIDTH],
    input  iqOneHotT selectedVector [ISSUE_WIDTH],
    input  alIndexT  selectedActiveListPtr [ISSUE_WIDTH],
    input  logic     toRecoveryPhase,
    input  logic     recoveryFromRwStage,
    input  iqOneHotT flushIqEntry,
    input  alIndexT  flushRangeHeadPtr,
    input  alIndexT  flushRangeTailPtr,
    input  logic     flushAllInsns,
    output logic     wakeup [ISSUE_WIDTH],
    output iqIndexT  wakeupPtr [ISSUE_WIDTH],
    output iqOneHotT wakeupVector [ISSUE_WIDTH],
    output logic     releaseEntry [ISSUE_WIDTH],
    output iqIndexT  releasePtr [ISSUE_WIDTH],
    output logic     flushedOpExist
);

    logic    intWindowActive;
    logic    memWindowActive;
    alIndexT flushHeadPtr;
    alIndexT flushTailPtr;
    logic    flushAll;

    flushWindowTracker flushWindowTracker_inst (
        .clk                (clk),
        .arstN              (arstN),
        .stall              (stall),
        .toRecoveryPhase    (toRecoveryPhase),
        .recoveryFromRwStage(recoveryFromRwStage),
        .flushRangeHeadPtr  (flushRangeHeadPtr),
        .flushRangeTailPtr  (flushRangeTailPtr),
        .flushAllInsns      (flushAllInsns),
        .intWindowActive    (intWindowActive),
        .memWindowActive    (memWindowActive),
        .flushHeadPtr       (flushHeadPtr),
        .flushTailPtr       (flushTailPtr),
        .flushAll           (flushAll),
        .flushedOpExist     (flushedOpExist)
    );

    // Integer lanes on the low slots.
    for (genvar i = 0; i < INT_ISSUE_WIDTH; i++) begin : genIntLane
        wakeupLane #(
            .latency(INT_LATENCY)
        ) wakeupLane_inst (
            .clk                  (clk),
            .arstN                (arstN),
            .stall                (stall),
            .toRecoveryPhase      (toRecoveryPhase),
            .recoveryFromRwStage  (recoveryFromRwStage),
            .selected             (selected[i]),
            .selectedPtr          (selectedPtr[i]),
            .selectedVector       (selectedVector[i]),
            .selectedActiveListPtr(selectedActiveListPtr[i]),
            .flushIqEntry         (flushIqEntry),
            .windowActive         (intWindowActive),
            .flushHeadPtr         (flushHeadPtr),
            .flushTailPtr         (flushTailPtr),
            .flushAll             (flushAll),
            .wakeup               (wakeup[i]),
            .wakeupPtr            (wakeupPtr[i]),
            .wakeupVector         (wakeupVector[i]),
            .releaseEntry         (releaseEntry[i]),
            .releasePtr           (releasePtr[i])
        );
    end

    // Memory lanes follow the integer slots.
    for (genvar i = 0; i < MEM_ISSUE_WIDTH; i++) begin : genMemLane
        localparam int SLOT = INT_ISSUE_WIDTH + i;

        wakeupLane #(
            .latency(MEM_LATENCY)
        ) wakeupLane_inst (
            .clk                  (clk),
            .arstN                (arstN),
            .stall                (stall),
            .toRecoveryPhase      (toRecoveryPhase),
            .recoveryFromRwStage  (recoveryFromRwStage),
            .selected             (selected[SLOT]),
            .selectedPtr          (selectedPtr[SLOT]),
            .selectedVector       (selectedVector[SLOT]),
            .selectedActiveListPtr(selectedActiveListPtr[SLOT]),
            .flushIqEntry         (flushIqEntry),
            .windowActive         (memWindowActive),
            .flushHeadPtr         (flushHeadPtr),
            .flushTailPtr         (flushTailPtr),
            .flushAll             (flushAll),
            .wakeup               (wakeup[SLOT]),
            .wakeupPtr            (wakeupPtr[SLOT]),
            .wakeupVector         (wakeupVector[SLOT]),
            .releaseEntry         (releaseEntry[SLOT]),
            .releasePtr           (releasePtr[SLOT])
        );
    end

endmodule

// File: source/flushWindowTracker.sv
// Tracks how long ops flushed by a register-write-stage recovery may remain in the lanes.
// One down-counter per lane group is loaded with that group's latency on recovery.
// The first decrement waits for a cycle without stall, since stage 0 holds on stall.

`timescale 1ns/1ps

module flushWindowTracker import wakeupPkg::*; (
    input  logic    clk,
    input  logic    arstN,
    input  logic    stall,
    input  logic    toRecoveryPhase,
    input  logic    recoveryFromRwStage,
    input  alIndexT flushRangeHeadPtr,
    input  alIndexT flushRangeTailPtr,
    input  logic    flushAllInsns,
    output logic    intWindowActive,
    output logic    memWindowActive,
    output alIndexT flushHeadPtr,
    output alIndexT flushTailPtr,
    output logic    flushAll,
    output logic    flushedOpExist
);

    localparam latCountT INT_COUNT_LOAD = latCountT'(INT_LATENCY);
    localparam latCountT MEM_COUNT_LOAD = latCountT'(MEM_LATENCY);

    latCountT intCount;
    latCountT memCount;
    logic     rwRecovery;

    assign rwRecovery = toRecoveryPhase && recoveryFromRwStage;

    // Next count of one group.
    // At full count the op is still in stage 0, which only moves without stall.
    function automatic latCountT nextCount(
        input latCountT count,
        input latCountT load,
        input logic stallNow
    );
        latCountT result;
        result = count;
        if (count == load) begin
            if (!stallNow) begin
                result = count - 1'b1;
            end
        end
        else if (count != '0) begin
            result = count - 1'b1;
        end
        return result;
    endfunction

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            intCount <= '0;
            memCount <= '0;
            flushHeadPtr <= '0;
            flushTailPtr <= '0;
            flushAll <= 1'b0;
        end
        else if (rwRecovery) begin
            intCount <= INT_COUNT_LOAD;
            memCount <= MEM_COUNT_LOAD;
            flushHeadPtr <= flushRangeHeadPtr;
            flushTailPtr <= flushRangeTailPtr;
            flushAll <= flushAllInsns;
        end
        else begin
            intCount <= nextCount(intCount, INT_COUNT_LOAD, stall);
            memCount <= nextCount(memCount, MEM_COUNT_LOAD, stall);
        end
    end

    assign intWindowActive = (intCount != '0);
    assign memWindowActive = (memCount != '0);

    // Reported to recovery so it can wait for the lanes to drain.
    assign flushedOpExist = intWindowActive || memWindowActive;

endmodule

// File: source/wakeupLane.sv
// One issue lane of the wakeup pipeline register.
// latency must be at least 1; stage 0 captures the select, stage latency-1 drives the outputs.
// Only stage 0 holds on stall; a one-stage lane gates its outputs during stall instead.
// Wakeup is suppressed for ops inside the latched flush range while windowActive is set.

`timescale 1ns/1ps

module wakeupLane import wakeupPkg::*; #(
    parameter int latency = 1
) (
    input  logic     clk,
    input  logic     arstN,
    input  logic     stall,
    input  logic     toRecoveryPhase,
    input  logic     recoveryFromRwStage,
    input  logic     selected,
    input  iqIndexT  selectedPtr,
    input  iqOneHotT selectedVector,
    input  alIndexT  selectedActiveListPtr,
    input  iqOneHotT flushIqEntry,
    input  logic     windowActive,
    input  alIndexT  flushHeadPtr,
    input  alIndexT  flushTailPtr,
    input  logic     flushAll,
    output logic     wakeup,
    output iqIndexT  wakeupPtr,
    output iqOneHotT wakeupVector,
    output logic     releaseEntry,
    output iqIndexT  releasePtr
);

    localparam int LAST = latency - 1;

    // A lane with a single stage has no later stage to take a bubble.
    localparam bit GATE_ON_STALL = (latency == 1);

    // Stage registers with stage 0 as the entry.
    logic     validQ [latency];
    iqIndexT  ptrQ [latency];
    iqOneHotT vectorQ [latency];
    alIndexT  alPtrQ [latency];

    logic     captureValid;
    iqOneHotT captureVector;
    logic     commitRecovery;
    logic     outGate;
    logic     flushHit;

    // An entry flushed in the cycle it is selected never enters the lane.
    assign captureValid = selected && !flushIqEntry[selectedPtr];

    // Producers flushed this cycle must not be woken up by this op.
    assign captureVector = selectedVector & ~flushIqEntry;

    assign commitRecovery = toRecoveryPhase && !recoveryFromRwStage;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < latency; i++) begin
                validQ[i] <= 1'b0;
                ptrQ[i] <= '0;
                vectorQ[i] <= '0;
                alPtrQ[i] <= '0;
            end
        end
        else if (commitRecovery) begin
            // Everything in flight is squashed.
            for (int i = 0; i < latency; i++) begin
                validQ[i] <= 1'b0;
                vectorQ[i] <= '0;
            end
        end
        else if (!stall) begin
            validQ[0] <= captureValid;
            ptrQ[0] <= selectedPtr;
            vectorQ[0] <= captureVector;
            alPtrQ[0] <= selectedActiveListPtr;
            for (int i = 1; i < latency; i++) begin
                validQ[i] <= validQ[i-1];
                ptrQ[i] <= ptrQ[i-1];
                vectorQ[i] <= vectorQ[i-1];
                alPtrQ[i] <= alPtrQ[i-1];
            end
        end
        else begin
            // Stage 0 holds the stalled op.
            // Stage 1 gets a bubble and the later stages keep draining.
            for (int i = 1; i < latency; i++) begin
                if (i == 1) begin
                    validQ[i] <= 1'b0;
                    vectorQ[i] <= '0;
                end
                else begin
                    validQ[i] <= validQ[i-1];
                    ptrQ[i] <= ptrQ[i-1];
                    vectorQ[i] <= vectorQ[i-1];
                    alPtrQ[i] <= alPtrQ[i-1];
                end
            end
        end
    end

    // In a one-stage lane the held op is presented again after the stall.
    assign outGate = GATE_ON_STALL && stall;

    // Selective flush check on the op leaving the lane.
    assign flushHit = windowActive &&
        inFlushRange(flushAll, flushHeadPtr, flushTailPtr, alPtrQ[LAST]);

    // The issue-queue entry is freed even for a flushed op.
    assign releaseEntry = validQ[LAST] && !outGate;
    assign releasePtr = ptrQ[LAST];

    assign wakeup = releaseEntry && !flushHit;
    assign wakeupPtr = ptrQ[LAST];
    assign wakeupVector = outGate ? '0 : vectorQ[LAST];

endmodule

// File: source/wakeupPkg.sv
// Shared widths, latencies and pointer types of the wakeup pipeline register.
// Slots 0 to INT_ISSUE_WIDTH-1 are integer lanes and the rest are memory lanes.
// The active list is treated as a circular buffer of AL_ENTRIES entries.

package wakeupPkg;

    // Issue slot counts per lane group.
    localparam int INT_ISSUE_WIDTH = 2;
    localparam int MEM_ISSUE_WIDTH = 2;
    localparam int ISSUE_WIDTH = INT_ISSUE_WIDTH + MEM_ISSUE_WIDTH;

    // Pipe depth between select and wakeup for each group.
    localparam int INT_LATENCY = 1;
    localparam int MEM_LATENCY = 3;

    // Scheduler structure sizes.
    localparam int IQ_ENTRIES = 16;
    localparam int AL_ENTRIES = 64;

    localparam int IQ_INDEX_WIDTH = $clog2(IQ_ENTRIES);
    localparam int AL_INDEX_WIDTH = $clog2(AL_ENTRIES);

    // The counter must hold the deepest lane latency.
    localparam int LAT_COUNT_WIDTH = $clog2(MEM_LATENCY + 1);

    // Pointer into the issue queue.
    typedef logic [IQ_INDEX_WIDTH-1:0] iqIndexT;

    // One bit per issue-queue entry, used for producer and flush vectors.
    typedef logic [IQ_ENTRIES-1:0] iqOneHotT;

    // Pointer into the active list.
    typedef logic [AL_INDEX_WIDTH-1:0] alIndexT;

    // Remaining cycles in which a flushed op may still sit in a lane group.
    typedef logic [LAT_COUNT_WIDTH-1:0] latCountT;

    // True when ptr is covered by a flush.
    // The range runs from head up to but not including tail, and wraps
    // around the end of the active list. Head equal to tail means empty.
    function automatic logic inFlushRange(
        input logic flushAll,
        input alIndexT head,
        input alIndexT tail,
        input alIndexT ptr
    );
        logic inRange;
        if (head == tail) begin
            inRange = 1'b0;
        end
        else if (head < tail) begin
            inRange = (ptr >= head) && (ptr < tail);
        end
        else begin
            // Wrapped range.
            inRange = (ptr >= head) || (ptr < tail);
        end
        return flushAll || inRange;
    endfunction

endpackage
